//--- crypt_package.sv
package crypt_package;

  // Bus and block geometry
  localparam int WORD_W          = 32;
  localparam int WORDS_PER_BLOCK = 4;
  localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
  localparam int COUNT_W         = 16;
  localparam int REG_OFF_W       = 4;

  typedef logic [WORD_W-1:0]                  word_t;
  typedef logic [31:0]                        addr_t;
  typedef logic [BLOCK_W-1:0]                 block_t;
  typedef logic [COUNT_W-1:0]                 count_t;
  typedef logic [$clog2(WORDS_PER_BLOCK)-1:0] word_idx_t;
  typedef logic [REG_OFF_W-1:0]               reg_off_t;

  // Byte strides for linear addressing
  localparam addr_t WORD_BYTES  = 32'd4;
  localparam addr_t BLOCK_BYTES = 32'd16;

  // Register map, word offsets of byte addresses 0x00 to 0x20
  localparam reg_off_t REG_SRC    = 4'd0;
  localparam reg_off_t REG_DST    = 4'd1;
  localparam reg_off_t REG_COUNT  = 4'd2;
  localparam reg_off_t REG_KEY0   = 4'd3;
  localparam reg_off_t REG_KEY1   = 4'd4;
  localparam reg_off_t REG_KEY2   = 4'd5;
  localparam reg_off_t REG_KEY3   = 4'd6;
  localparam reg_off_t REG_CTRL   = 4'd7;
  localparam reg_off_t REG_STATUS = 4'd8;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_STARTING,
    CTRL_READ_REQ,
    CTRL_READ_WAIT,
    CTRL_WORKING,
    CTRL_WRITE_REQ,
    CTRL_WRITE_WAIT,
    CTRL_FINISHED
  } ctrl_state_t;

endpackage

//--- stream_ctrl_if.sv
`timescale 1ns/1ps

interface stream_ctrl_if
  import crypt_package::*;
();

  // Request side, driven by the controller
  logic  req_start;
  logic  is_write;
  addr_t base_addr;

  // Status side, driven by the streamer
  logic  ready;
  logic  done;

  modport ctrl (
    output req_start,
    output is_write,
    output base_addr,
    input  ready,
    input  done
  );

  modport streamer (
    input  req_start,
    input  is_write,
    input  base_addr,
    output ready,
    output done
  );

endinterface

//--- crypt_regfile.sv
`timescale 1ns/1ps

module crypt_regfile
  import crypt_package::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  logic   s_cyc_i,
  input  logic   s_stb_i,
  input  logic   s_we_i,
  input  addr_t  s_adr_i,
  input  word_t  s_dat_i,
  output word_t  s_dat_o,
  output logic   s_ack_o,
  output logic   start_o,
  output addr_t  src_addr_o,
  output addr_t  dst_addr_o,
  output count_t block_count_o,
  output block_t key_o,
  output logic   done_o,
  input  logic   job_done_i,
  input  logic   busy_i
);

  reg_off_t reg_off;
  logic     access;
  logic     wr_en;
  logic     ack_q;
  logic     done_q;
  addr_t    src_q;
  addr_t    dst_q;
  count_t   count_q;
  block_t   key_q;

  assign reg_off = s_adr_i[REG_OFF_W+1:2];

  // First cycle of a strobe, ack follows one cycle later
  assign access = s_cyc_i & s_stb_i & ~ack_q;
  assign wr_en  = access & s_we_i;

  // Start is only honoured while the controller is idle
  assign start_o = wr_en & (reg_off == REG_CTRL) & s_dat_i[0] & ~busy_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (start_o) begin
        done_q <= 1'b0;
      end else if (job_done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // Job configuration and key
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (reg_off)
        REG_SRC:   src_q          <= s_dat_i;
        REG_DST:   dst_q          <= s_dat_i;
        REG_COUNT: count_q        <= s_dat_i[COUNT_W-1:0];
        REG_KEY0:  key_q[31:0]    <= s_dat_i;
        REG_KEY1:  key_q[63:32]   <= s_dat_i;
        REG_KEY2:  key_q[95:64]   <= s_dat_i;
        REG_KEY3:  key_q[127:96]  <= s_dat_i;
        default: ;
      endcase
    end
  end

  // Read-back, held stable by the address until ack
  always_comb begin
    case (reg_off)
      REG_SRC:    s_dat_o = src_q;
      REG_DST:    s_dat_o = dst_q;
      REG_COUNT:  s_dat_o = word_t'(count_q);
      REG_KEY0:   s_dat_o = key_q[31:0];
      REG_KEY1:   s_dat_o = key_q[63:32];
      REG_KEY2:   s_dat_o = key_q[95:64];
      REG_KEY3:   s_dat_o = key_q[127:96];
      REG_STATUS: s_dat_o = {30'd0, busy_i, done_q};
      default:    s_dat_o = '0;
    endcase
  end

  assign s_ack_o       = ack_q;
  assign src_addr_o    = src_q;
  assign dst_addr_o    = dst_q;
  assign block_count_o = count_q;
  assign key_o         = key_q;
  assign done_o        = done_q;

endmodule

//--- crypt_ctrl_fsm.sv
`timescale 1ns/1ps

module crypt_ctrl_fsm
  import crypt_package::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        start_i,
  input  addr_t       src_addr_i,
  input  addr_t       dst_addr_i,
  input  count_t      block_count_i,
  stream_ctrl_if.ctrl stream,
  output logic        engine_start_o,
  output logic        job_done_o,
  output logic        busy_o
);

  ctrl_state_t current_state;
  ctrl_state_t next_state;
  count_t      remaining_q;
  count_t      block_index_q;
  addr_t       block_offset;
  logic        writing;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      current_state <= CTRL_IDLE;
    end else begin
      current_state <= next_state;
    end
  end

  // Blocks left and position of the current block
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      remaining_q   <= '0;
      block_index_q <= '0;
    end else if (current_state == CTRL_IDLE && start_i) begin
      remaining_q   <= block_count_i;
      block_index_q <= '0;
    end else if (current_state == CTRL_WRITE_WAIT && stream.done) begin
      remaining_q   <= remaining_q - count_t'(1);
      block_index_q <= block_index_q + count_t'(1);
    end
  end

  always_comb begin
    next_state = current_state;
    case (current_state)
      CTRL_IDLE: begin
        if (start_i) begin
          next_state = CTRL_STARTING;
        end
      end
      CTRL_STARTING: begin
        // Empty job goes straight to done
        if (remaining_q == '0) begin
          next_state = CTRL_FINISHED;
        end else begin
          next_state = CTRL_READ_REQ;
        end
      end
      CTRL_READ_REQ: begin
        if (stream.ready) begin
          next_state = CTRL_READ_WAIT;
        end
      end
      CTRL_READ_WAIT: begin
        if (stream.done) begin
          next_state = CTRL_WORKING;
        end
      end
      CTRL_WORKING: begin
        next_state = CTRL_WRITE_REQ;
      end
      CTRL_WRITE_REQ: begin
        if (stream.ready) begin
          next_state = CTRL_WRITE_WAIT;
        end
      end
      CTRL_WRITE_WAIT: begin
        if (stream.done) begin
          if (remaining_q == count_t'(1)) begin
            next_state = CTRL_FINISHED;
          end else begin
            next_state = CTRL_READ_REQ;
          end
        end
      end
      CTRL_FINISHED: begin
        next_state = CTRL_IDLE;
      end
      default: begin
        next_state = CTRL_IDLE;
      end
    endcase
  end

  assign writing      = (current_state == CTRL_WRITE_REQ);
  assign block_offset = addr_t'(block_index_q) * BLOCK_BYTES;

  // Request only while the streamer is idle
  assign stream.req_start = (current_state == CTRL_READ_REQ || writing) && stream.ready;
  assign stream.is_write  = writing;
  assign stream.base_addr = writing ? dst_addr_i + block_offset : src_addr_i + block_offset;

  assign engine_start_o = (current_state == CTRL_WORKING);
  assign job_done_o     = (current_state == CTRL_FINISHED);
  assign busy_o         = (current_state != CTRL_IDLE);

endmodule

//--- word_streamer.sv
`timescale 1ns/1ps

module word_streamer
  import crypt_package::*;
(
  input  logic            clk,
  input  logic            reset_n,
  stream_ctrl_if.streamer stream,
  input  block_t          wr_block_i,
  output block_t          rd_block_o,
  output logic            m_cyc_o,
  output logic            m_stb_o,
  output logic            m_we_o,
  output addr_t           m_adr_o,
  output word_t           m_dat_o,
  input  word_t           m_dat_i,
  input  logic            m_ack_i
);

  logic      active_q;
  logic      we_q;
  logic      done_q;
  logic      accept;
  logic      beat;
  logic      last_word;
  word_idx_t word_cnt_q;
  addr_t     addr_q;
  block_t    buf_q;

  assign accept    = stream.req_start & ~active_q;
  assign beat      = active_q & m_ack_i;
  assign last_word = (word_cnt_q == word_idx_t'(WORDS_PER_BLOCK - 1));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q   <= 1'b0;
      we_q       <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        active_q   <= 1'b1;
        we_q       <= stream.is_write;
        word_cnt_q <= '0;
      end else if (beat) begin
        word_cnt_q <= word_cnt_q + word_idx_t'(1);
        if (last_word) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  // Word 0 sits at the bottom, read words enter at the top
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= stream.base_addr;
      if (stream.is_write) begin
        buf_q <= wr_block_i;
      end
    end else if (beat) begin
      addr_q <= addr_q + WORD_BYTES;
      buf_q  <= {m_dat_i, buf_q[BLOCK_W-1:WORD_W]};
    end
  end

  // Strobe stays up across the four beats of a block
  assign m_cyc_o = active_q;
  assign m_stb_o = active_q;
  assign m_we_o  = we_q;
  assign m_adr_o = addr_q;
  assign m_dat_o = buf_q[WORD_W-1:0];

  assign rd_block_o   = buf_q;
  assign stream.ready = ~active_q;
  assign stream.done  = done_q;

endmodule

//--- whitening_engine.sv
`timescale 1ns/1ps

module whitening_engine
  import crypt_package::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  logic   start_i,
  input  block_t key_i,
  input  block_t block_i,
  output block_t wr_block_o
);

  block_t whitened;
  block_t result_q;

  // Key whitening, one XOR per word lane
  always_comb begin
    for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
      whitened[k*WORD_W +: WORD_W] = block_i[k*WORD_W +: WORD_W] ^ key_i[k*WORD_W +: WORD_W];
    end
  end

  // Result held until the next start
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result_q <= '0;
    end else if (start_i) begin
      result_q <= whitened;
    end
  end

  assign wr_block_o = result_q;

endmodule

//--- crypt_top.sv
`timescale 1ns/1ps

module crypt_top
  import crypt_package::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  s_cyc_i,
  input  logic  s_stb_i,
  input  logic  s_we_i,
  input  addr_t s_adr_i,
  input  word_t s_dat_i,
  output word_t s_dat_o,
  output logic  s_ack_o,
  output logic  m_cyc_o,
  output logic  m_stb_o,
  output logic  m_we_o,
  output addr_t m_adr_o,
  output word_t m_dat_o,
  input  word_t m_dat_i,
  input  logic  m_ack_i,
  output logic  done_o
);

  logic   start;
  logic   job_done;
  logic   busy;
  logic   engine_start;
  addr_t  src_addr;
  addr_t  dst_addr;
  count_t block_count;
  block_t key;
  block_t rd_block;
  block_t wr_block;

  stream_ctrl_if stream_if ();

  crypt_regfile i_crypt_regfile (
    .clk           (clk),
    .reset_n       (reset_n),
    .s_cyc_i       (s_cyc_i),
    .s_stb_i       (s_stb_i),
    .s_we_i        (s_we_i),
    .s_adr_i       (s_adr_i),
    .s_dat_i       (s_dat_i),
    .s_dat_o       (s_dat_o),
    .s_ack_o       (s_ack_o),
    .start_o       (start),
    .src_addr_o    (src_addr),
    .dst_addr_o    (dst_addr),
    .block_count_o (block_count),
    .key_o         (key),
    .done_o        (done_o),
    .job_done_i    (job_done),
    .busy_i        (busy)
  );

  crypt_ctrl_fsm i_crypt_ctrl_fsm (
    .clk            (clk),
    .reset_n        (reset_n),
    .start_i        (start),
    .src_addr_i     (src_addr),
    .dst_addr_i     (dst_addr),
    .block_count_i  (block_count),
    .stream         (stream_if.ctrl),
    .engine_start_o (engine_start),
    .job_done_o     (job_done),
    .busy_o         (busy)
  );

  word_streamer i_word_streamer (
    .clk        (clk),
    .reset_n    (reset_n),
    .stream     (stream_if.streamer),
    .wr_block_i (wr_block),
    .rd_block_o (rd_block),
    .m_cyc_o    (m_cyc_o),
    .m_stb_o    (m_stb_o),
    .m_we_o     (m_we_o),
    .m_adr_o    (m_adr_o),
    .m_dat_o    (m_dat_o),
    .m_dat_i    (m_dat_i),
    .m_ack_i    (m_ack_i)
  );

  whitening_engine i_whitening_engine (
    .clk        (clk),
    .reset_n    (reset_n),
    .start_i    (engine_start),
    .key_i      (key),
    .block_i    (rd_block),
    .wr_block_o (wr_block)
  );

endmodule

//--- tb_crypt_top.sv
`timescale 1ns/1ps

module tb_crypt_top
  import crypt_package::*;
();

  localparam int BUS_TIMEOUT  = 20;
  localparam int DONE_TIMEOUT = 2000;
  localparam int MEM_WORDS    = 1024;
  localparam int NUM_JOBS     = 4;

  typedef struct packed {
    addr_t  src;
    addr_t  dst;
    count_t count;
    block_t key;
    logic   retrigger;
  } job_t;

  logic   clk;
  logic   reset_n;
  logic   s_cyc_i;
  logic   s_stb_i;
  logic   s_we_i;
  addr_t  s_adr_i;
  word_t  s_dat_i;
  word_t  s_dat_o;
  logic   s_ack_o;
  logic   m_cyc_o;
  logic   m_stb_o;
  logic   m_we_o;
  addr_t  m_adr_o;
  word_t  m_dat_o;
  word_t  m_dat_i;
  logic   m_ack_i;
  logic   done_o;

  word_t  mem [0:MEM_WORDS-1];
  job_t   jobs [0:NUM_JOBS-1];
  int     ack_wait;
  int     transfers;
  int     checks;
  int     errors;
  int     timeouts;

  crypt_top i_crypt_top (
    .clk     (clk),
    .reset_n (reset_n),
    .s_cyc_i (s_cyc_i),
    .s_stb_i (s_stb_i),
    .s_we_i  (s_we_i),
    .s_adr_i (s_adr_i),
    .s_dat_i (s_dat_i),
    .s_dat_o (s_dat_o),
    .s_ack_o (s_ack_o),
    .m_cyc_o (m_cyc_o),
    .m_stb_o (m_stb_o),
    .m_we_o  (m_we_o),
    .m_adr_o (m_adr_o),
    .m_dat_o (m_dat_o),
    .m_dat_i (m_dat_i),
    .m_ack_i (m_ack_i),
    .done_o  (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory model acks after 0 to 3 idle cycles for one cycle
  always @(negedge clk) begin
    if (m_ack_i) begin
      m_ack_i = 1'b0;
    end else if (reset_n && m_cyc_o && m_stb_o) begin
      if (ack_wait < 0) begin
        ack_wait = $urandom % 4;
      end
      if (ack_wait == 0) begin
        if (m_we_o) begin
          mem[m_adr_o[11:2]] = m_dat_o;
        end else begin
          m_dat_i = mem[m_adr_o[11:2]];
        end
        m_ack_i   = 1'b1;
        ack_wait  = -1;
        transfers = transfers + 1;
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9e3779b1) ^ 32'h5a5a0f0f;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, expected);
    end
  endtask

  // Called on a falling edge and returns on the ack edge
  task automatic write_reg(input reg_off_t off, input word_t data);
    int cycles;
    cycles  = 0;
    s_cyc_i = 1'b1;
    s_stb_i = 1'b1;
    s_we_i  = 1'b1;
    s_adr_i = addr_t'(off) << 2;
    s_dat_i = data;
    do begin
      @(negedge clk);
      cycles++;
    end while (!s_ack_o && cycles < BUS_TIMEOUT);
    if (!s_ack_o) begin
      timeouts++;
      $display("Timeout: no ack for the register write at offset %0d", off);
    end
    s_cyc_i = 1'b0;
    s_stb_i = 1'b0;
    s_we_i  = 1'b0;
  endtask

  task automatic read_reg(input reg_off_t off, output word_t data);
    int cycles;
    cycles  = 0;
    s_cyc_i = 1'b1;
    s_stb_i = 1'b1;
    s_we_i  = 1'b0;
    s_adr_i = addr_t'(off) << 2;
    do begin
      @(negedge clk);
      cycles++;
    end while (!s_ack_o && cycles < BUS_TIMEOUT);
    if (!s_ack_o) begin
      timeouts++;
      $display("Timeout: no ack for the register read at offset %0d", off);
    end
    data    = s_dat_o;
    s_cyc_i = 1'b0;
    s_stb_i = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done_o && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done_o) begin
      timeouts++;
      $display("Timeout: done_o did not rise within %0d cycles", DONE_TIMEOUT);
    end
  endtask

  initial begin
    job_t  job;
    word_t rd;
    word_t cfg [0:6];
    int    src_w;
    int    dst_w;
    void'($urandom(32'h331dd51c));
    reset_n   = 1'b0;
    s_cyc_i   = 1'b0;
    s_stb_i   = 1'b0;
    s_we_i    = 1'b0;
    s_adr_i   = '0;
    s_dat_i   = '0;
    m_dat_i   = '0;
    m_ack_i   = 1'b0;
    ack_wait  = -1;
    transfers = 0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end

    // Each row holds src, dst, block count, key and a second start while busy
    jobs[0] = '{32'h100, 32'h200, 16'd1, 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0, 1'b0};
    jobs[1] = '{32'h300, 32'h400, 16'd3, 128'hdeadbeef_01234567_89abcdef_fedcba98, 1'b0};
    jobs[2] = '{32'h500, 32'h600, 16'd0, 128'h11111111_22222222_33333333_44444444, 1'b0};
    jobs[3] = '{32'h700, 32'h800, 16'd2, 128'hcafef00d_5555aaaa_0000ffff_13579bdf, 1'b1};

    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    for (int j = 0; j < NUM_JOBS; j++) begin
      job   = jobs[j];
      src_w = job.src[11:2];
      dst_w = job.dst[11:2];
      for (int i = 0; i < job.count * WORDS_PER_BLOCK; i++) begin
        mem[src_w + i] = $urandom;
      end
      transfers = 0;

      cfg[0] = job.src;
      cfg[1] = job.dst;
      cfg[2] = word_t'(job.count);
      for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
        cfg[3 + k] = job.key[k*WORD_W +: WORD_W];
      end
      for (int k = 0; k < 7; k++) begin
        write_reg(reg_off_t'(REG_SRC + k), cfg[k]);
      end
      for (int k = 0; k < 7; k++) begin
        read_reg(reg_off_t'(REG_SRC + k), rd);
        check_word($sformatf("register %0d", k), rd, cfg[k]);
      end

      write_reg(REG_CTRL, 32'h1);
      check_flag("done_o after start", done_o, 1'b0);
      if (job.count != 0) begin
        // Expect busy set and done cleared
        read_reg(REG_STATUS, rd);
        check_word("status while running", rd, 32'h2);
      end
      if (job.retrigger) begin
        write_reg(REG_CTRL, 32'h1);
      end

      wait_done();
      // Window in which an accepted second start would show up
      repeat (10) @(negedge clk);
      check_flag("done_o after job", done_o, 1'b1);
      read_reg(REG_STATUS, rd);
      check_word("status after job", rd, 32'h1);
      check_word("master transfers", word_t'(transfers),
                 word_t'(job.count * 2 * WORDS_PER_BLOCK));

      for (int i = 0; i < job.count * WORDS_PER_BLOCK; i++) begin
        check_word($sformatf("dst word %0d", i), mem[dst_w + i],
                   mem[src_w + i] ^ job.key[(i % WORDS_PER_BLOCK)*WORD_W +: WORD_W]);
      end
      // The block past the count stays untouched
      for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
        src_w = dst_w + job.count * WORDS_PER_BLOCK + i;
        check_word($sformatf("word %0d past dst", i), mem[src_w], fill_word(src_w));
      end
    end

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
crypt_package.sv
stream_ctrl_if.sv
crypt_regfile.sv
crypt_ctrl_fsm.sv
word_streamer.sv
whitening_engine.sv
crypt_top.sv
tb_crypt_top.sv
